//--- core_pkg.sv
package core_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // alu operations
    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_LUI    = 3'd6;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd7;

    // hi/lo operations
    localparam int HILO_OP_W = 3;
    localparam logic [HILO_OP_W-1:0] HILO_NONE  = 3'd0;
    localparam logic [HILO_OP_W-1:0] HILO_MULT  = 3'd1;
    localparam logic [HILO_OP_W-1:0] HILO_MULTU = 3'd2;
    localparam logic [HILO_OP_W-1:0] HILO_MADD  = 3'd3;
    localparam logic [HILO_OP_W-1:0] HILO_MSUB  = 3'd4;
    localparam logic [HILO_OP_W-1:0] HILO_MTHI  = 3'd5;
    localparam logic [HILO_OP_W-1:0] HILO_MTLO  = 3'd6;

    // result source
    localparam int RES_SEL_W = 2;
    localparam logic [RES_SEL_W-1:0] RES_ALU = 2'd0;
    localparam logic [RES_SEL_W-1:0] RES_HI  = 2'd1;
    localparam logic [RES_SEL_W-1:0] RES_LO  = 2'd2;

endpackage

//--- decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_in_valid,
    input  isa_pkg::instr_word_t             i_in_instr,
    input  logic                             i_ex_ready,
    output logic                             o_in_ready,
    output logic                             o_valid,
    output logic [core_pkg::REG_ADDR_W-1:0]  o_rs,
    output logic [core_pkg::REG_ADDR_W-1:0]  o_rt,
    output logic [core_pkg::REG_ADDR_W-1:0]  o_rd,
    output logic                             o_wen,
    output logic [core_pkg::ALU_OP_W-1:0]    o_alu_op,
    output logic [core_pkg::HILO_OP_W-1:0]   o_hilo_op,
    output logic [core_pkg::RES_SEL_W-1:0]   o_res_sel,
    output logic                             o_use_imm,
    output logic [core_pkg::WORD_W-1:0]      o_imm
);

    logic                            dec_wen;
    logic [core_pkg::REG_ADDR_W-1:0] dec_rd;
    logic [core_pkg::ALU_OP_W-1:0]   dec_alu_op;
    logic [core_pkg::HILO_OP_W-1:0]  dec_hilo_op;
    logic [core_pkg::RES_SEL_W-1:0]  dec_res_sel;
    logic                            dec_use_imm;
    logic [core_pkg::WORD_W-1:0]     dec_imm;
    logic                            take;

    // register empties or moves on this cycle
    assign o_in_ready = ~o_valid | i_ex_ready;
    assign take       = i_in_valid & o_in_ready;

    always_comb begin
        dec_wen     = 1'b0;
        dec_rd      = i_in_instr.i.rt;
        dec_alu_op  = core_pkg::ALU_PASS_B;
        dec_hilo_op = core_pkg::HILO_NONE;
        dec_res_sel = core_pkg::RES_ALU;
        dec_use_imm = 1'b0;
        dec_imm     = {{(core_pkg::WORD_W-16){1'b0}}, i_in_instr.i.imm};
        case (i_in_instr.r.opcode)
            isa_pkg::OP_SPECIAL: begin
                // r-type results go to rd
                dec_rd  = i_in_instr.r.rd;
                dec_wen = 1'b1;
                case (i_in_instr.r.funct)
                    isa_pkg::FN_ADDU:  dec_alu_op = core_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU:  dec_alu_op = core_pkg::ALU_SUB;
                    isa_pkg::FN_AND:   dec_alu_op = core_pkg::ALU_AND;
                    isa_pkg::FN_OR:    dec_alu_op = core_pkg::ALU_OR;
                    isa_pkg::FN_XOR:   dec_alu_op = core_pkg::ALU_XOR;
                    isa_pkg::FN_SLT:   dec_alu_op = core_pkg::ALU_SLT;
                    isa_pkg::FN_MFHI:  dec_res_sel = core_pkg::RES_HI;
                    isa_pkg::FN_MFLO:  dec_res_sel = core_pkg::RES_LO;
                    isa_pkg::FN_MULT:  dec_hilo_op = core_pkg::HILO_MULT;
                    isa_pkg::FN_MULTU: dec_hilo_op = core_pkg::HILO_MULTU;
                    isa_pkg::FN_MTHI:  dec_hilo_op = core_pkg::HILO_MTHI;
                    isa_pkg::FN_MTLO:  dec_hilo_op = core_pkg::HILO_MTLO;
                    default:           dec_wen = 1'b0;
                endcase
                // hi/lo writers leave the register file alone
                if (dec_hilo_op != core_pkg::HILO_NONE) begin
                    dec_wen = 1'b0;
                end
            end
            isa_pkg::OP_SPECIAL2: begin
                dec_rd = i_in_instr.r.rd;
                if (i_in_instr.r.funct == isa_pkg::FN_MADD) begin
                    dec_hilo_op = core_pkg::HILO_MADD;
                end else if (i_in_instr.r.funct == isa_pkg::FN_MSUB) begin
                    dec_hilo_op = core_pkg::HILO_MSUB;
                end
            end
            isa_pkg::OP_ADDIU: begin
                dec_wen     = 1'b1;
                dec_alu_op  = core_pkg::ALU_ADD;
                dec_use_imm = 1'b1;
                dec_imm     = {{(core_pkg::WORD_W-16){i_in_instr.i.imm[15]}},
                               i_in_instr.i.imm};
            end
            isa_pkg::OP_ORI: begin
                dec_wen     = 1'b1;
                dec_alu_op  = core_pkg::ALU_OR;
                dec_use_imm = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                dec_wen     = 1'b1;
                dec_alu_op  = core_pkg::ALU_LUI;
                dec_use_imm = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else if (take) begin
            o_valid <= 1'b1;
        end else if (i_ex_ready) begin
            o_valid <= 1'b0;
        end
    end

    // decoded payload
    always_ff @(posedge clk) begin
        if (take) begin
            o_rs      <= i_in_instr.r.rs;
            o_rt      <= i_in_instr.r.rt;
            o_rd      <= dec_rd;
            o_wen     <= dec_wen;
            o_alu_op  <= dec_alu_op;
            o_hilo_op <= dec_hilo_op;
            o_res_sel <= dec_res_sel;
            o_use_imm <= dec_use_imm;
            o_imm     <= dec_imm;
        end
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rs,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rt,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic                            i_wen,
    input  logic [core_pkg::ALU_OP_W-1:0]   i_alu_op,
    input  logic [core_pkg::HILO_OP_W-1:0]  i_hilo_op,
    input  logic [core_pkg::RES_SEL_W-1:0]  i_res_sel,
    input  logic                            i_use_imm,
    input  logic [core_pkg::WORD_W-1:0]     i_imm,
    input  logic [core_pkg::WORD_W-1:0]     i_rd1,
    input  logic [core_pkg::WORD_W-1:0]     i_rd2,
    input  logic [core_pkg::WORD_W-1:0]     i_hi,
    input  logic [core_pkg::WORD_W-1:0]     i_lo,
    input  logic                            i_out_ready,
    output logic                            o_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] o_ra1,
    output logic [core_pkg::REG_ADDR_W-1:0] o_ra2,
    output logic                            o_hilo_update,
    output logic [core_pkg::WORD_W-1:0]     o_a,
    output logic [core_pkg::WORD_W-1:0]     o_b,
    output logic                            o_out_valid,
    output logic                            o_out_wen,
    output logic [core_pkg::REG_ADDR_W-1:0] o_out_rd,
    output logic [core_pkg::WORD_W-1:0]     o_out_data
);

    logic                        move_in;
    logic                        held_writes;
    logic [core_pkg::WORD_W-1:0] reg_b;
    logic [core_pkg::WORD_W-1:0] alu_res;
    logic [core_pkg::WORD_W-1:0] result;

    assign o_ready = ~o_out_valid | i_out_ready;
    assign move_in = i_valid & o_ready;
    assign o_ra1   = i_rs;
    assign o_ra2   = i_rt;

    // held beat not yet in the register file
    assign held_writes = o_out_valid & o_out_wen & (o_out_rd != '0);

    assign o_a   = (held_writes && (o_out_rd == i_rs)) ? o_out_data : i_rd1;
    assign reg_b = (held_writes && (o_out_rd == i_rt)) ? o_out_data : i_rd2;
    assign o_b   = i_use_imm ? i_imm : reg_b;

    assign o_hilo_update = move_in & (i_hilo_op != core_pkg::HILO_NONE);

    always_comb begin
        case (i_alu_op)
            core_pkg::ALU_ADD:    alu_res = o_a + o_b;
            core_pkg::ALU_SUB:    alu_res = o_a - o_b;
            core_pkg::ALU_AND:    alu_res = o_a & o_b;
            core_pkg::ALU_OR:     alu_res = o_a | o_b;
            core_pkg::ALU_XOR:    alu_res = o_a ^ o_b;
            // signed compare
            core_pkg::ALU_SLT:    alu_res = {{(core_pkg::WORD_W-1){1'b0}},
                                             $signed(o_a) < $signed(o_b)};
            core_pkg::ALU_LUI:    alu_res = {o_b[15:0], 16'h0000};
            core_pkg::ALU_PASS_B: alu_res = o_b;
            default:              alu_res = o_b;
        endcase
    end

    always_comb begin
        case (i_res_sel)
            core_pkg::RES_HI: result = i_hi;
            core_pkg::RES_LO: result = i_lo;
            default:          result = alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_out_valid <= 1'b0;
        end else if (move_in) begin
            o_out_valid <= 1'b1;
        end else if (i_out_ready) begin
            o_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (move_in) begin
            o_out_wen  <= i_wen;
            o_out_rd   <= i_rd;
            o_out_data <= result;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (o_out_valid && !i_out_ready) |=>
            (o_out_valid && $stable(o_out_wen) && $stable(o_out_rd)
             && $stable(o_out_data)));

endmodule

//--- hilo_unit.sv
`timescale 1ns/10ps

module hilo_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           i_update,
    input  logic [core_pkg::HILO_OP_W-1:0] i_op,
    input  logic [core_pkg::WORD_W-1:0]    i_a,
    input  logic [core_pkg::WORD_W-1:0]    i_b,
    output logic [core_pkg::WORD_W-1:0]    o_hi,
    output logic [core_pkg::WORD_W-1:0]    o_lo
);

    logic signed [2*core_pkg::WORD_W-1:0] prod_s;
    logic        [2*core_pkg::WORD_W-1:0] prod_u;
    logic        [2*core_pkg::WORD_W-1:0] acc;
    logic        [2*core_pkg::WORD_W-1:0] acc_next;

    assign prod_s = $signed(i_a) * $signed(i_b);
    assign prod_u = {{core_pkg::WORD_W{1'b0}}, i_a} * {{core_pkg::WORD_W{1'b0}}, i_b};
    assign acc    = {o_hi, o_lo};

    // madd/msub carry and borrow across the lo/hi boundary
    always_comb begin
        case (i_op)
            core_pkg::HILO_MULT:  acc_next = prod_s;
            core_pkg::HILO_MULTU: acc_next = prod_u;
            core_pkg::HILO_MADD:  acc_next = acc + prod_s;
            core_pkg::HILO_MSUB:  acc_next = acc - prod_s;
            core_pkg::HILO_MTHI:  acc_next = {i_a, o_lo};
            core_pkg::HILO_MTLO:  acc_next = {o_hi, i_a};
            default:              acc_next = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_hi <= '0;
            o_lo <= '0;
        end else if (i_update) begin
            o_hi <= acc_next[2*core_pkg::WORD_W-1:core_pkg::WORD_W];
            o_lo <= acc_next[core_pkg::WORD_W-1:0];
        end
    end

endmodule

//--- isa_pkg.sv
package isa_pkg;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1C;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_ORI      = 6'h0D;
    localparam logic [5:0] OP_LUI      = 6'h0F;

    // funct field under SPECIAL
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2A;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;

    // funct field under SPECIAL2
    localparam logic [5:0] FN_MADD = 6'h00;
    localparam logic [5:0] FN_MSUB = 6'h04;

    // one instruction word, read as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_word_t;

endpackage

//--- list.f
isa_pkg.sv
core_pkg.sv
decode_stage.sv
reg_file.sv
hilo_unit.sv
execute_stage.sv
mini_mips_core.sv
tb_mini_mips_core.sv

//--- mini_mips_core.sv
`timescale 1ns/10ps

module mini_mips_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_in_valid,
    input  isa_pkg::instr_word_t            i_in_instr,
    input  logic                            i_out_ready,
    output logic                            o_in_ready,
    output logic                            o_out_valid,
    output logic                            o_out_wen,
    output logic [core_pkg::REG_ADDR_W-1:0] o_out_rd,
    output logic [core_pkg::WORD_W-1:0]     o_out_data
);

    logic                            d_valid;
    logic                            ex_ready;
    logic [core_pkg::REG_ADDR_W-1:0] d_rs;
    logic [core_pkg::REG_ADDR_W-1:0] d_rt;
    logic [core_pkg::REG_ADDR_W-1:0] d_rd;
    logic                            d_wen;
    logic [core_pkg::ALU_OP_W-1:0]   d_alu_op;
    logic [core_pkg::HILO_OP_W-1:0]  d_hilo_op;
    logic [core_pkg::RES_SEL_W-1:0]  d_res_sel;
    logic                            d_use_imm;
    logic [core_pkg::WORD_W-1:0]     d_imm;
    logic [core_pkg::REG_ADDR_W-1:0] ra1;
    logic [core_pkg::REG_ADDR_W-1:0] ra2;
    logic [core_pkg::WORD_W-1:0]     rd1;
    logic [core_pkg::WORD_W-1:0]     rd2;
    logic [core_pkg::WORD_W-1:0]     hi;
    logic [core_pkg::WORD_W-1:0]     lo;
    logic [core_pkg::WORD_W-1:0]     op_a;
    logic [core_pkg::WORD_W-1:0]     op_b;
    logic                            hilo_update;
    logic                            rf_we;

    // register write happens when the result beat is accepted
    assign rf_we = o_out_valid & i_out_ready & o_out_wen;

    decode_stage decode_stage_i (
        .clk, .reset, .i_in_valid, .i_in_instr, .i_ex_ready(ex_ready), .o_in_ready,
        .o_valid(d_valid), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd), .o_wen(d_wen),
        .o_alu_op(d_alu_op), .o_hilo_op(d_hilo_op), .o_res_sel(d_res_sel),
        .o_use_imm(d_use_imm), .o_imm(d_imm)
    );

    reg_file reg_file_i (
        .clk, .reset, .i_ra1(ra1), .i_ra2(ra2), .i_we(rf_we), .i_wa(o_out_rd),
        .i_wd(o_out_data), .o_rd1(rd1), .o_rd2(rd2)
    );

    hilo_unit hilo_unit_i (
        .clk, .reset, .i_update(hilo_update), .i_op(d_hilo_op), .i_a(op_a), .i_b(op_b),
        .o_hi(hi), .o_lo(lo)
    );

    execute_stage execute_stage_i (
        .clk, .reset, .i_valid(d_valid), .i_rs(d_rs), .i_rt(d_rt), .i_rd(d_rd),
        .i_wen(d_wen), .i_alu_op(d_alu_op), .i_hilo_op(d_hilo_op), .i_res_sel(d_res_sel),
        .i_use_imm(d_use_imm), .i_imm(d_imm), .i_rd1(rd1), .i_rd2(rd2), .i_hi(hi),
        .i_lo(lo), .i_out_ready, .o_ready(ex_ready), .o_ra1(ra1), .o_ra2(ra2),
        .o_hilo_update(hilo_update), .o_a(op_a), .o_b(op_b), .o_out_valid,
        .o_out_wen, .o_out_rd, .o_out_data
    );

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_ra1,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_ra2,
    input  logic                            i_we,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_wa,
    input  logic [core_pkg::WORD_W-1:0]     i_wd,
    output logic [core_pkg::WORD_W-1:0]     o_rd1,
    output logic [core_pkg::WORD_W-1:0]     o_rd2
);

    // register zero has no storage
    logic [core_pkg::WORD_W-1:0] regs [1:core_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k < core_pkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_wa != '0)) begin
            regs[i_wa] <= i_wd;
        end
    end

    // write-through on a same-cycle hit
    always_comb begin
        if (i_ra1 == '0) begin
            o_rd1 = '0;
        end else if (i_we && (i_wa == i_ra1)) begin
            o_rd1 = i_wd;
        end else begin
            o_rd1 = regs[i_ra1];
        end
        if (i_ra2 == '0) begin
            o_rd2 = '0;
        end else if (i_we && (i_wa == i_ra2)) begin
            o_rd2 = i_wd;
        end else begin
            o_rd2 = regs[i_ra2];
        end
    end

    // data written on one edge reads back on the next cycle
    a_read_back: assert property (@(posedge clk) disable iff (reset)
        (i_we && (i_wa != '0)) |=>
            (((i_ra1 != $past(i_wa)) || (i_we && (i_wa == i_ra1))
              || (o_rd1 == $past(i_wd)))
             && ((i_ra2 != $past(i_wa)) || (i_we && (i_wa == i_ra2))
                 || (o_rd2 == $past(i_wd)))));

endmodule

//--- tb_mini_mips_core.sv
`timescale 1ns/10ps

module tb_mini_mips_core;

    logic                            clk;
    logic                            reset;
    logic                            i_in_valid;
    isa_pkg::instr_word_t            i_in_instr;
    logic                            i_out_ready;
    logic                            o_in_ready;
    logic                            o_out_valid;
    logic                            o_out_wen;
    logic [core_pkg::REG_ADDR_W-1:0] o_out_rd;
    logic [core_pkg::WORD_W-1:0]     o_out_data;

    // one entry per instruction, in issue order
    string                           name_q[$];
    isa_pkg::instr_word_t            instr_q[$];
    logic                            exp_wen_q[$];
    logic [core_pkg::REG_ADDR_W-1:0] exp_rd_q[$];
    logic [core_pkg::WORD_W-1:0]     exp_data_q[$];

    int          num_tests   = 0;
    int          out_idx     = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    mini_mips_core dut_i (
        .clk, .reset, .i_in_valid, .i_in_instr, .i_out_ready, .o_in_ready,
        .o_out_valid, .o_out_wen, .o_out_rd, .o_out_data
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic isa_pkg::instr_word_t special_word(input int rs, input int rt,
                                                          input int rd, input logic [5:0] fn);
        isa_pkg::instr_word_t w;
        w.r.opcode = isa_pkg::OP_SPECIAL;
        w.r.rs     = 5'(rs);
        w.r.rt     = 5'(rt);
        w.r.rd     = 5'(rd);
        w.r.shamt  = 5'd0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic isa_pkg::instr_word_t special2_word(input int rs, input int rt,
                                                           input logic [5:0] fn);
        isa_pkg::instr_word_t w;
        w        = special_word(rs, rt, 0, fn);
        w.r.opcode = isa_pkg::OP_SPECIAL2;
        return w;
    endfunction

    function automatic isa_pkg::instr_word_t imm_word(input logic [5:0] op, input int rs,
                                                      input int rt, input int imm);
        isa_pkg::instr_word_t w;
        w.i.opcode = op;
        w.i.rs     = 5'(rs);
        w.i.rt     = 5'(rt);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    task automatic add_test(input string name, input isa_pkg::instr_word_t instr,
                            input int wen, input int rd, input logic [31:0] data);
        name_q.push_back(name);
        instr_q.push_back(instr);
        exp_wen_q.push_back(wen != 0);
        exp_rd_q.push_back(5'(rd));
        exp_data_q.push_back(data);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic build_table();
        add_test("addiu_pos", imm_word(isa_pkg::OP_ADDIU, 0, 1, 'h5), 1, 1, 32'h5);
        add_test("addiu_neg", imm_word(isa_pkg::OP_ADDIU, 0, 2, 'hfffd), 1, 2, 32'hffff_fffd);
        add_test("ori_zext", imm_word(isa_pkg::OP_ORI, 0, 3, 'h8001), 1, 3, 32'h8001);
        add_test("lui", imm_word(isa_pkg::OP_LUI, 0, 4, 'h1234), 1, 4, 32'h1234_0000);
        // a write to register zero still shows on the beat
        add_test("addiu_r0", imm_word(isa_pkg::OP_ADDIU, 0, 0, 'h7), 1, 0, 32'h7);
        add_test("addu_r0_read", special_word(0, 1, 5, isa_pkg::FN_ADDU), 1, 5, 32'h5);
        add_test("addu", special_word(1, 2, 6, isa_pkg::FN_ADDU), 1, 6, 32'h2);
        add_test("subu", special_word(1, 4, 7, isa_pkg::FN_SUBU), 1, 7, 32'hedcc_0005);
        add_test("and", special_word(3, 2, 8, isa_pkg::FN_AND), 1, 8, 32'h8001);
        add_test("or", special_word(3, 4, 9, isa_pkg::FN_OR), 1, 9, 32'h1234_8001);
        add_test("xor", special_word(4, 2, 10, isa_pkg::FN_XOR), 1, 10, 32'hedcb_fffd);
        add_test("slt_neg", special_word(2, 1, 11, isa_pkg::FN_SLT), 1, 11, 32'h1);
        add_test("slt_pos", special_word(1, 2, 12, isa_pkg::FN_SLT), 1, 12, 32'h0);
        // dependent chain
        add_test("fwd_base", imm_word(isa_pkg::OP_ADDIU, 0, 13, 'h10), 1, 13, 32'h10);
        add_test("fwd_double", special_word(13, 13, 14, isa_pkg::FN_ADDU), 1, 14, 32'h20);
        add_test("fwd_chain", special_word(14, 13, 15, isa_pkg::FN_ADDU), 1, 15, 32'h30);
        add_test("fwd_sub", special_word(15, 14, 16, isa_pkg::FN_SUBU), 1, 16, 32'h10);
        // -3 * 5 signed and then 0xfffffffd * 5 unsigned
        add_test("mult", special_word(2, 1, 0, isa_pkg::FN_MULT), 0, 0, 32'h0);
        add_test("mfhi_mult", special_word(0, 0, 17, isa_pkg::FN_MFHI), 1, 17, 32'hffff_ffff);
        add_test("mflo_mult", special_word(0, 0, 18, isa_pkg::FN_MFLO), 1, 18, 32'hffff_fff1);
        add_test("multu", special_word(2, 1, 0, isa_pkg::FN_MULTU), 0, 0, 32'h0);
        add_test("mfhi_multu", special_word(0, 0, 19, isa_pkg::FN_MFHI), 1, 19, 32'h4);
        add_test("mflo_multu", special_word(0, 0, 20, isa_pkg::FN_MFLO), 1, 20, 32'hffff_fff1);
        add_test("mthi", special_word(4, 0, 0, isa_pkg::FN_MTHI), 0, 0, 32'h0);
        add_test("mtlo", special_word(3, 0, 0, isa_pkg::FN_MTLO), 0, 0, 32'h0);
        add_test("mfhi_mthi", special_word(0, 0, 21, isa_pkg::FN_MFHI), 1, 21, 32'h1234_0000);
        add_test("mflo_mtlo", special_word(0, 0, 22, isa_pkg::FN_MFLO), 1, 22, 32'h8001);
        // msub of 25 from a hi/lo pair of 5 borrows through lo into hi
        add_test("mthi_zero", special_word(0, 0, 0, isa_pkg::FN_MTHI), 0, 0, 32'h0);
        add_test("mtlo_five", special_word(1, 0, 0, isa_pkg::FN_MTLO), 0, 0, 32'h0);
        add_test("msub", special2_word(1, 1, isa_pkg::FN_MSUB), 0, 0, 32'h0);
        add_test("mfhi_msub", special_word(0, 0, 23, isa_pkg::FN_MFHI), 1, 23, 32'hffff_ffff);
        add_test("mflo_msub", special_word(0, 0, 24, isa_pkg::FN_MFLO), 1, 24, 32'hffff_ffec);
        add_test("madd", special2_word(4, 1, isa_pkg::FN_MADD), 0, 0, 32'h0);
        add_test("mfhi_madd", special_word(0, 0, 25, isa_pkg::FN_MFHI), 1, 25, 32'h0);
        add_test("mflo_madd", special_word(0, 0, 26, isa_pkg::FN_MFLO), 1, 26, 32'h5b03_ffec);
        add_test("madd_neg", special2_word(2, 2, isa_pkg::FN_MADD), 0, 0, 32'h0);
        add_test("mflo_madd_neg", special_word(0, 0, 27, isa_pkg::FN_MFLO), 1, 27, 32'h5b03_fff5);
        add_test("mthi_src", imm_word(isa_pkg::OP_ADDIU, 0, 28, 'h77), 1, 28, 32'h77);
        add_test("mthi_fwd", special_word(28, 0, 0, isa_pkg::FN_MTHI), 0, 0, 32'h0);
        add_test("mfhi_fwd", special_word(0, 0, 29, isa_pkg::FN_MFHI), 1, 29, 32'h77);
        add_test("unsupported", 32'hfc00_0000, 0, 0, 32'h0);
        add_test("mflo_reg_read", special_word(26, 0, 30, isa_pkg::FN_ADDU), 1, 30, 32'h5b03_ffec);
        num_tests = name_q.size();
    endtask

    // rd and data only carry meaning on writing beats
    task automatic check_beat();
        string msg;
        if (out_idx >= num_tests) begin
            fail_run("an output beat arrived after the last expected instruction");
        end
        assert (o_out_wen === exp_wen_q[out_idx]) else begin
            msg = $sformatf("ERROR %s: wen expected %0b actual %0b", name_q[out_idx],
                            exp_wen_q[out_idx], o_out_wen);
            fail_run(msg);
        end
        if (exp_wen_q[out_idx]) begin
            assert ((o_out_rd === exp_rd_q[out_idx]) && (o_out_data === exp_data_q[out_idx]))
            else begin
                msg = $sformatf("ERROR %s: expected r%0d=%h actual r%0d=%h", name_q[out_idx],
                                exp_rd_q[out_idx], exp_data_q[out_idx], o_out_rd, o_out_data);
                fail_run(msg);
            end
        end
        out_idx++;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count++;
        end
        if (cycle_count > cycle_limit) begin
            fail_run("timeout: not every instruction produced its output beat in time");
        end
    end

    // output back-pressure and beat collection
    initial begin
        void'($urandom(32'h6b194d47));
        i_out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_out_ready = ($urandom % 4) != 0;
            @(negedge clk);
            if (o_out_valid && i_out_ready) begin
                check_beat();
            end
        end
    end

    initial begin
        reset      = 1'b1;
        i_in_valid = 1'b0;
        i_in_instr = '0;
        build_table();
        cycle_limit = 4 * num_tests + 20;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int k = 0; k < num_tests; k++) begin
            i_in_valid = 1'b1;
            i_in_instr = instr_q[k];
            @(negedge clk);
            while (!o_in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        i_in_valid = 1'b0;
        wait (out_idx == num_tests);
        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
